// File: common/heap_consts.svh
// Width, header layout and granule constants; included by the allocator RTL and its testbench
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

// address and size width
`define HEAP_DATA_W 32

// header is size word then next pointer, 4 bytes apart
`define HEAP_HDR_SIZE 8

// request rounding unit and smallest split remainder
`define HEAP_GRANULE 8

`define HEAP_NULL 0 // end of list

`endif

// File: common/heap_pkg.sv
// Shared types of the heap allocator: free-list header and memory operation codes
`default_nettype none

`include "heap_consts.svh"

package heap_pkg;

  // one free-list header as seen by the core
  typedef struct packed {
    logic [`HEAP_DATA_W-1:0] addr;
    logic [`HEAP_DATA_W-1:0] size;
    logic [`HEAP_DATA_W-1:0] next;
  } header_t;

  typedef enum logic [1:0] {
    MEM_LOAD       = 2'd0, // read size and next
    MEM_STORE_HDR  = 2'd1, // write size and next
    MEM_STORE_NEXT = 2'd2  // write next only
  } mem_op_e;

endpackage

`default_nettype wire

// File: rtl/request_intake.sv
// Request intake; takes one alloc or free request, rounds its size and holds it until done
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module request_intake (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    req_is_alloc_i,
  input  logic [`HEAP_DATA_W-1:0] req_size_i,
  input  logic [`HEAP_DATA_W-1:0] req_addr_i,
  input  logic                    op_done_i,
  output logic                    op_busy_o,
  output logic                    op_is_alloc_o,
  output logic [`HEAP_DATA_W-1:0] op_size_o,
  output logic [`HEAP_DATA_W-1:0] op_addr_o
);

  localparam logic [`HEAP_DATA_W-1:0] GRAN_MASK = `HEAP_DATA_W'(`HEAP_GRANULE - 1);

  logic                    busy_q, accept;
  logic                    is_alloc_q;
  logic [`HEAP_DATA_W-1:0] size_q, addr_q;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (op_done_i) begin
      busy_q <= 1'b0; // ready again the cycle after the result handshake
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      is_alloc_q <= req_is_alloc_i;
      size_q     <= (req_size_i + GRAN_MASK) & ~GRAN_MASK; // round up to granule
      addr_q     <= req_addr_i;
    end
  end

  assign op_busy_o     = busy_q;
  assign op_is_alloc_o = is_alloc_q;
  assign op_size_o     = size_q;
  assign op_addr_o     = addr_q;

  // walker only finishes a request that is held
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_done_i |-> op_busy_o);

endmodule

`default_nettype wire

// File: walker/block_splitter.sv
// Block splitter; derives the headers to store for an allocation split or unlink, or a free insert
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module block_splitter (
  input  logic                    op_is_alloc_i,
  input  logic [`HEAP_DATA_W-1:0] op_size_i,
  input  logic [`HEAP_DATA_W-1:0] op_addr_i,
  input  heap_pkg::header_t       cur_hdr_i,
  input  heap_pkg::header_t       prev_hdr_i,
  output heap_pkg::header_t       split_hdr_o,
  output heap_pkg::header_t       link_hdr_o,
  output logic                    split_use_o
);
  import heap_pkg::*;

  localparam logic [`HEAP_DATA_W-1:0] HDR_SIZE = `HEAP_DATA_W'(`HEAP_HDR_SIZE);
  localparam logic [`HEAP_DATA_W-1:0] GRANULE  = `HEAP_DATA_W'(`HEAP_GRANULE);

  header_t new_hdr;
  logic    can_split;

  // at least one granule of payload left behind the new header
  assign can_split = (cur_hdr_i.size >= op_size_i + HDR_SIZE + GRANULE);

  always_comb begin
    new_hdr = '0;
    if (op_is_alloc_i) begin
      new_hdr.addr = cur_hdr_i.addr + HDR_SIZE + op_size_i;
      new_hdr.size = cur_hdr_i.size - op_size_i - HDR_SIZE;
      new_hdr.next = cur_hdr_i.next;
    end else begin
      new_hdr.addr = op_addr_i - HDR_SIZE; // size field already in memory
      new_hdr.next = prev_hdr_i.next;
    end
  end

  assign split_use_o = op_is_alloc_i ? can_split : 1'b1;
  assign split_hdr_o = new_hdr;

  always_comb begin
    link_hdr_o = prev_hdr_i;
    if (op_is_alloc_i && !can_split) link_hdr_o.next = cur_hdr_i.next; // unlink whole block
    else link_hdr_o.next = new_hdr.addr;
  end

endmodule

`default_nettype wire

// File: walker/free_list_walker.sv
// Free-list walker FSM; walks headers from the anchor, picks fit or insert point, sequences stores
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module free_list_walker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    op_busy_i,
  input  logic                    op_is_alloc_i,
  input  logic [`HEAP_DATA_W-1:0] op_size_i,
  input  logic [`HEAP_DATA_W-1:0] op_addr_i,
  output logic                    op_done_o,
  input  logic [`HEAP_DATA_W-1:0] free_list_ptr_i,
  output heap_pkg::header_t       cur_hdr_o,
  output heap_pkg::header_t       prev_hdr_o,
  output logic                    cmd_valid_o,
  input  logic                    cmd_ready_i,
  output heap_pkg::mem_op_e       cmd_op_o,
  output heap_pkg::header_t       cmd_hdr_o,
  input  logic                    cmd_rsp_valid_i,
  input  heap_pkg::header_t       cmd_rsp_hdr_i,
  input  heap_pkg::header_t       split_hdr_i,
  input  heap_pkg::header_t       link_hdr_i,
  input  logic                    split_use_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output logic                    rsp_is_alloc_o,
  output logic [`HEAP_DATA_W-1:0] rsp_addr_o
);
  import heap_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_LOAD, ST_WAIT, ST_DECIDE, ST_WR_NEW, ST_WR_LINK, ST_RETURN
  } walk_state_e;

  localparam logic [`HEAP_DATA_W-1:0] HDR_SIZE = `HEAP_DATA_W'(`HEAP_HDR_SIZE);
  localparam logic [`HEAP_DATA_W-1:0] NULL_PTR = `HEAP_DATA_W'(`HEAP_NULL);

  walk_state_e             state_q, after_q;
  header_t                 cur_q, prev_q;
  logic [`HEAP_DATA_W-1:0] load_addr_q, rsp_addr_q;

  logic at_anchor, fits, at_end, ins_here;

  // anchor has size zero and is never handed out
  assign at_anchor = (cur_q.addr == free_list_ptr_i);
  assign fits      = !at_anchor && (cur_q.size >= op_size_i);
  assign at_end    = (cur_q.next == NULL_PTR);
  assign ins_here  = at_end || (cur_q.next > op_addr_i); // address ordered insert point

  always_comb begin
    cmd_valid_o = 1'b0;
    cmd_op_o    = MEM_LOAD;
    cmd_hdr_o   = '0;
    case (state_q)
      ST_LOAD: begin
        cmd_valid_o    = 1'b1;
        cmd_hdr_o.addr = load_addr_q;
      end
      ST_WR_NEW: begin
        cmd_valid_o = 1'b1;
        cmd_op_o    = op_is_alloc_i ? MEM_STORE_HDR : MEM_STORE_NEXT; // freed size stays
        cmd_hdr_o   = split_hdr_i;
      end
      ST_WR_LINK: begin
        cmd_valid_o = 1'b1;
        cmd_op_o    = MEM_STORE_NEXT;
        cmd_hdr_o   = link_hdr_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      after_q <= ST_DECIDE;
    end else begin
      case (state_q)
        ST_IDLE: if (op_busy_i) state_q <= ST_LOAD;
        ST_LOAD: begin
          if (cmd_ready_i) begin
            state_q <= ST_WAIT;
            after_q <= ST_DECIDE;
          end
        end
        ST_WAIT: if (cmd_rsp_valid_i) state_q <= after_q;
        ST_DECIDE: begin
          if (op_is_alloc_i) begin
            if (fits) state_q <= split_use_i ? ST_WR_NEW : ST_WR_LINK;
            else if (at_end) state_q <= ST_RETURN; // no block fits
            else state_q <= ST_LOAD;
          end else begin
            state_q <= ins_here ? ST_WR_NEW : ST_LOAD;
          end
        end
        ST_WR_NEW: begin
          if (cmd_ready_i) begin
            state_q <= ST_WAIT;
            after_q <= ST_WR_LINK;
          end
        end
        ST_WR_LINK: begin
          if (cmd_ready_i) begin
            state_q <= ST_WAIT;
            after_q <= ST_RETURN;
          end
        end
        ST_RETURN: if (rsp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) load_addr_q <= free_list_ptr_i; // walk starts at the anchor
    if (state_q == ST_WAIT && cmd_rsp_valid_i && after_q == ST_DECIDE) cur_q <= cmd_rsp_hdr_i;
    if (state_q == ST_DECIDE) begin
      if (!op_is_alloc_i) begin
        prev_q      <= cur_q; // also the link target once stopped
        load_addr_q <= cur_q.next;
        rsp_addr_q  <= '0;
      end else if (fits) begin
        rsp_addr_q <= cur_q.addr + HDR_SIZE;
      end else if (at_end) begin
        rsp_addr_q <= '0;
      end else begin
        prev_q      <= cur_q;
        load_addr_q <= cur_q.next;
      end
    end
  end

  assign cur_hdr_o      = cur_q;
  assign prev_hdr_o     = prev_q;
  assign rsp_valid_o    = (state_q == ST_RETURN);
  assign rsp_addr_o     = rsp_addr_q;
  assign rsp_is_alloc_o = op_is_alloc_i;
  assign op_done_o      = rsp_valid_o && rsp_ready_i;

  // writer holds no earlier command when a new one is raised
  a_one_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |-> cmd_ready_i);

endmodule

`default_nettype wire

// File: rtl/header_writer.sv
// Memory port driver; issues one header load or store at a time and returns the response header
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module header_writer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  heap_pkg::mem_op_e       cmd_op_i,
  input  heap_pkg::header_t       cmd_hdr_i,
  output logic                    cmd_rsp_valid_o,
  output heap_pkg::header_t       cmd_rsp_hdr_o,
  output logic                    mem_valid_o,
  input  logic                    mem_ready_i,
  output heap_pkg::mem_op_e       mem_op_o,
  output logic [`HEAP_DATA_W-1:0] mem_addr_o,
  output logic [`HEAP_DATA_W-1:0] mem_size_o,
  output logic [`HEAP_DATA_W-1:0] mem_next_o,
  input  logic                    mem_rsp_valid_i,
  input  logic [`HEAP_DATA_W-1:0] mem_rsp_size_i,
  input  logic [`HEAP_DATA_W-1:0] mem_rsp_next_i
);
  import heap_pkg::*;

  logic    busy_q, mem_valid_q, rsp_valid_q;
  mem_op_e op_q;
  header_t hdr_q, rsp_hdr_q;

  assign cmd_ready_o = !busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      mem_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0; // single cycle pulse
      if (cmd_valid_i && cmd_ready_o) begin
        busy_q      <= 1'b1;
        mem_valid_q <= 1'b1;
      end else if (mem_valid_q && mem_ready_i) begin
        mem_valid_q <= 1'b0;
      end
      if (busy_q && mem_rsp_valid_i) begin
        busy_q      <= 1'b0;
        rsp_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      op_q  <= cmd_op_i;
      hdr_q <= cmd_hdr_i;
    end
    if (busy_q && mem_rsp_valid_i) begin
      rsp_hdr_q.addr <= hdr_q.addr; // tag with the requested address
      rsp_hdr_q.size <= mem_rsp_size_i;
      rsp_hdr_q.next <= mem_rsp_next_i;
    end
  end

  assign mem_valid_o     = mem_valid_q;
  assign mem_op_o        = op_q;
  assign mem_addr_o      = hdr_q.addr;
  assign mem_size_o      = hdr_q.size;
  assign mem_next_o      = hdr_q.next;
  assign cmd_rsp_valid_o = rsp_valid_q;
  assign cmd_rsp_hdr_o   = rsp_hdr_q;

  // back-pressure keeps the request on the bus unchanged
  a_mem_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_op_o) && $stable(mem_addr_o)
      && $stable(mem_size_o) && $stable(mem_next_o));

endmodule

`default_nettype wire

// File: rtl/heap_alloc_top.sv
// Heap allocator top level; connects request intake, free-list walker, splitter and memory port
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_alloc_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    req_is_alloc_i,
  input  logic [`HEAP_DATA_W-1:0] req_size_i,
  input  logic [`HEAP_DATA_W-1:0] req_addr_i,
  input  logic [`HEAP_DATA_W-1:0] free_list_ptr_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output logic                    rsp_is_alloc_o,
  output logic [`HEAP_DATA_W-1:0] rsp_addr_o,
  output logic                    mem_valid_o,
  input  logic                    mem_ready_i,
  output heap_pkg::mem_op_e       mem_op_o,
  output logic [`HEAP_DATA_W-1:0] mem_addr_o,
  output logic [`HEAP_DATA_W-1:0] mem_size_o,
  output logic [`HEAP_DATA_W-1:0] mem_next_o,
  input  logic                    mem_rsp_valid_i,
  input  logic [`HEAP_DATA_W-1:0] mem_rsp_size_i,
  input  logic [`HEAP_DATA_W-1:0] mem_rsp_next_i
);
  import heap_pkg::*;

  logic                    op_busy, op_is_alloc, op_done;
  logic [`HEAP_DATA_W-1:0] op_size, op_addr;

  header_t cur_hdr, prev_hdr, split_hdr, link_hdr;
  logic    split_use;

  logic    cmd_valid, cmd_ready, cmd_rsp_valid;
  mem_op_e cmd_op;
  header_t cmd_hdr, cmd_rsp_hdr;

  request_intake u_request_intake (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_is_alloc_i, .req_size_i, .req_addr_i,
    .op_done_i(op_done), .op_busy_o(op_busy), .op_is_alloc_o(op_is_alloc),
    .op_size_o(op_size), .op_addr_o(op_addr)
  );

  free_list_walker u_free_list_walker (
    .clk_i, .rst_ni,
    .op_busy_i(op_busy), .op_is_alloc_i(op_is_alloc), .op_size_i(op_size),
    .op_addr_i(op_addr), .op_done_o(op_done), .free_list_ptr_i,
    .cur_hdr_o(cur_hdr), .prev_hdr_o(prev_hdr),
    .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_op_o(cmd_op),
    .cmd_hdr_o(cmd_hdr), .cmd_rsp_valid_i(cmd_rsp_valid), .cmd_rsp_hdr_i(cmd_rsp_hdr),
    .split_hdr_i(split_hdr), .link_hdr_i(link_hdr), .split_use_i(split_use),
    .rsp_valid_o, .rsp_ready_i, .rsp_is_alloc_o, .rsp_addr_o
  );

  block_splitter u_block_splitter (
    .op_is_alloc_i(op_is_alloc), .op_size_i(op_size), .op_addr_i(op_addr),
    .cur_hdr_i(cur_hdr), .prev_hdr_i(prev_hdr),
    .split_hdr_o(split_hdr), .link_hdr_o(link_hdr), .split_use_o(split_use)
  );

  header_writer u_header_writer (
    .clk_i, .rst_ni,
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_op_i(cmd_op),
    .cmd_hdr_i(cmd_hdr), .cmd_rsp_valid_o(cmd_rsp_valid), .cmd_rsp_hdr_o(cmd_rsp_hdr),
    .mem_valid_o, .mem_ready_i, .mem_op_o, .mem_addr_o, .mem_size_o, .mem_next_o,
    .mem_rsp_valid_i, .mem_rsp_size_i, .mem_rsp_next_i
  );

endmodule

`default_nettype wire

// File: tests/heap_mem_model.sv
// Word memory model for the allocator's load/store port; random ready, answers two cycles later
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_mem_model (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    mem_valid_i,
  output logic                    mem_ready_o,
  input  heap_pkg::mem_op_e       mem_op_i,
  input  logic [`HEAP_DATA_W-1:0] mem_addr_i,
  input  logic [`HEAP_DATA_W-1:0] mem_size_i,
  input  logic [`HEAP_DATA_W-1:0] mem_next_i,
  output logic                    mem_rsp_valid_o,
  output logic [`HEAP_DATA_W-1:0] mem_rsp_size_o,
  output logic [`HEAP_DATA_W-1:0] mem_rsp_next_o,
  input  logic                    preload_en_i,
  input  logic [`HEAP_DATA_W-1:0] preload_addr_i,
  input  logic [`HEAP_DATA_W-1:0] preload_data_i
);
  import heap_pkg::*;

  logic [`HEAP_DATA_W-1:0] mem_q [128]; // 512 bytes
  logic [31:0]             lcg_q;
  logic                    ready_q, accept, pend_q, rsp_valid_q;
  logic [6:0]              size_idx, next_idx;
  logic [`HEAP_DATA_W-1:0] rsp_size_q, rsp_next_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  assign accept   = mem_valid_i && ready_q;
  assign size_idx = mem_addr_i[8:2];
  assign next_idx = size_idx + 7'd1; // next pointer sits one word up

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      lcg_q       <= 32'he5b48e02;
      ready_q     <= 1'b0;
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      lcg_q       <= lcg_step(lcg_q);
      ready_q     <= (lcg_q[17:16] != 2'b00); // ready roughly three cycles in four
      pend_q      <= accept;
      rsp_valid_q <= pend_q;
    end
  end

  always @(posedge clk_i) begin
    if (preload_en_i) begin
      mem_q[preload_addr_i[8:2]] <= preload_data_i;
    end else if (accept) begin
      rsp_size_q <= mem_q[size_idx];
      rsp_next_q <= mem_q[next_idx];
      case (mem_op_i)
        MEM_STORE_HDR: begin
          mem_q[size_idx] <= mem_size_i;
          mem_q[next_idx] <= mem_next_i;
        end
        MEM_STORE_NEXT: mem_q[next_idx] <= mem_next_i;
        default: ;
      endcase
    end
  end

  assign mem_ready_o     = ready_q;
  assign mem_rsp_valid_o = rsp_valid_q;
  assign mem_rsp_size_o  = rsp_size_q;
  assign mem_rsp_next_o  = rsp_next_q;

endmodule

`default_nettype wire

// File: tests/heap_alloc_tb.sv
// Testbench for heap_alloc_top; builds a free list in the memory model, runs alloc and free
`timescale 1ns/1ps
`default_nettype none

`include "heap_consts.svh"

module heap_alloc_tb;
  import heap_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_TESTS   = 5;
  localparam int OP_TIMEOUT  = 1000; // cycles
  localparam int WATCHDOG_NS = (NUM_TESTS * 2000 + 200) * CLK_PERIOD;
  localparam logic [`HEAP_DATA_W-1:0] HDR    = `HEAP_DATA_W'(`HEAP_HDR_SIZE);
  localparam logic [`HEAP_DATA_W-1:0] GRAN   = `HEAP_DATA_W'(`HEAP_GRANULE);
  localparam logic [`HEAP_DATA_W-1:0] NULLP  = `HEAP_DATA_W'(`HEAP_NULL);
  localparam logic [`HEAP_DATA_W-1:0] ANCHOR = 32'h10;

  logic        clk = 1'b0;
  logic        rst_n, req_valid, req_ready, req_is_alloc;
  logic [31:0] req_size, req_addr, free_list_ptr;
  logic        rsp_valid, rsp_ready, rsp_is_alloc;
  logic [31:0] rsp_addr;
  logic        mem_valid, mem_ready, mem_rsp_valid;
  mem_op_e     mem_op;
  logic [31:0] mem_addr, mem_size, mem_next, mem_rsp_size, mem_rsp_next;
  logic        preload_en;
  logic [31:0] preload_addr, preload_data;

  int          proc_errors = 0;
  int          prop_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          errs_mark = 0;
  logic [31:0] exp_rsp_addr;
  logic        exp_rsp_is_alloc;

  // expected free list behind the anchor, in address order
  logic [31:0] ref_addr [$];
  logic [31:0] ref_size [$];
  logic [31:0] alloc_size [logic [31:0]]; // header size field of handed-out blocks

  always #(CLK_PERIOD / 2) clk = ~clk;

  heap_alloc_top u_heap_alloc_top (
    .clk_i(clk), .rst_ni(rst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_is_alloc_i(req_is_alloc),
    .req_size_i(req_size), .req_addr_i(req_addr), .free_list_ptr_i(free_list_ptr),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_is_alloc_o(rsp_is_alloc),
    .rsp_addr_o(rsp_addr),
    .mem_valid_o(mem_valid), .mem_ready_i(mem_ready), .mem_op_o(mem_op),
    .mem_addr_o(mem_addr), .mem_size_o(mem_size), .mem_next_o(mem_next),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_size_i(mem_rsp_size),
    .mem_rsp_next_i(mem_rsp_next)
  );

  heap_mem_model u_mem_model (
    .clk_i(clk), .rst_ni(rst_n),
    .mem_valid_i(mem_valid), .mem_ready_o(mem_ready), .mem_op_i(mem_op),
    .mem_addr_i(mem_addr), .mem_size_i(mem_size), .mem_next_i(mem_next),
    .mem_rsp_valid_o(mem_rsp_valid), .mem_rsp_size_o(mem_rsp_size),
    .mem_rsp_next_o(mem_rsp_next),
    .preload_en_i(preload_en), .preload_addr_i(preload_addr), .preload_data_i(preload_data)
  );

  a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp_addr == exp_rsp_addr && rsp_is_alloc == exp_rsp_is_alloc)
    else begin
      $display("CHECK FAILED at %0t: result 0x%08h kind %0b, expected 0x%08h kind %0b",
               $time, $sampled(rsp_addr), $sampled(rsp_is_alloc), exp_rsp_addr,
               exp_rsp_is_alloc);
      prop_errors++;
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_addr) && $stable(rsp_is_alloc))
    else begin
      $display("CHECK FAILED at %0t: result changed while held", $time);
      prop_errors++;
    end

  // no new request while a result waits
  a_req_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !req_ready)
    else begin
      $display("CHECK FAILED at %0t: req_ready high with a result pending", $time);
      prop_errors++;
    end

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      proc_errors++;
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return u_mem_model.mem_q[addr[8:2]];
  endfunction

  task automatic poke(input logic [31:0] addr, input logic [31:0] data);
    preload_en   = 1'b1;
    preload_addr = addr;
    preload_data = data;
    @(posedge clk);
    #1;
    preload_en = 1'b0;
  endtask

  task automatic build_list();
    logic [31:0] prev;
    for (int i = 0; i < 128; i++) begin
      poke(32'(i) << 2, 32'h5a5a_0000 ^ (32'(i) << 2));
    end
    ref_addr = '{32'h40, 32'h80, 32'hc0};
    ref_size = '{32'd24, 32'd8, 32'd64};
    poke(ANCHOR, 32'd0); // anchor has size zero
    prev = ANCHOR;
    foreach (ref_addr[i]) begin
      poke(prev + 32'd4, ref_addr[i]);
      poke(ref_addr[i], ref_size[i]);
      prev = ref_addr[i];
    end
    poke(prev + 32'd4, NULLP);
  endtask

  // first fit; split when a granule of payload is left past a new header
  function automatic logic [31:0] ref_alloc(input logic [31:0] req);
    logic [31:0] need, res;
    int hit;
    need = (req + GRAN - 32'd1) & ~(GRAN - 32'd1);
    res  = 32'd0;
    hit  = -1;
    foreach (ref_addr[i]) begin
      if (hit < 0 && ref_size[i] >= need) hit = i;
    end
    if (hit >= 0) begin
      res = ref_addr[hit] + HDR;
      alloc_size[res] = ref_size[hit];
      if (ref_size[hit] >= need + HDR + GRAN) begin
        ref_addr[hit] = ref_addr[hit] + HDR + need;
        ref_size[hit] = ref_size[hit] - need - HDR;
      end else begin
        ref_addr.delete(hit);
        ref_size.delete(hit);
      end
    end
    return res;
  endfunction

  function automatic void ref_free(input logic [31:0] payload);
    int pos;
    pos = ref_addr.size();
    for (int i = ref_addr.size() - 1; i >= 0; i--) begin
      if (ref_addr[i] > payload) pos = i;
    end
    ref_addr.insert(pos, payload - HDR);
    ref_size.insert(pos, alloc_size[payload]);
  endfunction

  task automatic check_list();
    logic [31:0] ptr;
    ptr = ANCHOR;
    expect_eq(mem_word(ANCHOR), 32'd0, "anchor size");
    foreach (ref_addr[i]) begin
      expect_eq(mem_word(ptr + 32'd4), ref_addr[i], $sformatf("next of 0x%08h", ptr));
      ptr = ref_addr[i];
      expect_eq(mem_word(ptr), ref_size[i], $sformatf("size of 0x%08h", ptr));
    end
    expect_eq(mem_word(ptr + 32'd4), NULLP, "list end");
  endtask

  task automatic run_op(input logic is_alloc, input logic [31:0] size, input logic [31:0] addr,
                        input logic [31:0] exp_addr, input int hold);
    int   cycles;
    logic was_ready;
    exp_rsp_addr     = exp_addr;
    exp_rsp_is_alloc = is_alloc;
    rsp_ready        = (hold == 0);
    req_valid        = 1'b1;
    req_is_alloc     = is_alloc;
    req_size         = size;
    req_addr         = addr;
    cycles           = 0;
    do begin
      was_ready = req_ready;
      @(posedge clk);
      #1;
      cycles++;
    end while (!was_ready && cycles < OP_TIMEOUT);
    req_valid = 1'b0;
    if (!was_ready) begin
      $display("the DUT never accepted the request");
      proc_errors++;
      return;
    end
    expect_eq({31'b0, req_ready}, 32'd0, "req_ready after accept");
    cycles = 0;
    while (!rsp_valid && cycles < OP_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!rsp_valid) begin
      $display("no result from the DUT within %0d cycles", OP_TIMEOUT);
      proc_errors++;
      return;
    end
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    rsp_ready = 1'b1;
    @(posedge clk);
    #1;
    expect_eq({31'b0, rsp_valid}, 32'd0, "rsp_valid after handshake");
    expect_eq({31'b0, req_ready}, 32'd1, "req_ready after handshake");
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = proc_errors + prop_errors - errs_mark;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d check(s) failed", tests_run, name, errs);
    end
    errs_mark = proc_errors + prop_errors;
  endtask

  initial begin : main
    logic [31:0] expected, first_payload;
    rst_n            = 1'b0;
    req_valid        = 1'b0;
    req_is_alloc     = 1'b0;
    req_size         = 32'd0;
    req_addr         = 32'd0;
    rsp_ready        = 1'b1;
    free_list_ptr    = ANCHOR;
    preload_en       = 1'b0;
    preload_addr     = 32'd0;
    preload_data     = 32'd0;
    exp_rsp_addr     = 32'd0;
    exp_rsp_is_alloc = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    expect_eq({31'b0, req_ready}, 32'd1, "req_ready after reset");
    expect_eq({31'b0, rsp_valid}, 32'd0, "rsp_valid after reset");
    expect_eq({31'b0, mem_valid}, 32'd0, "mem_valid after reset");
    build_list();

    first_payload = ref_alloc(32'd20); // rounds to 24, whole first block
    run_op(1'b1, 32'd20, 32'd0, first_payload, 0);
    check_list();
    finish_test("alloc 20 unlinks first block");

    expected = ref_alloc(32'd16);
    run_op(1'b1, 32'd16, 32'd0, expected, 0);
    check_list();
    finish_test("alloc 16 splits 64 byte block");

    expected = ref_alloc(32'd200);
    run_op(1'b1, 32'd200, 32'd0, expected, 0);
    check_list();
    finish_test("alloc 200 fails");

    ref_free(first_payload);
    run_op(1'b0, 32'd0, first_payload, 32'd0, 0);
    check_list();
    finish_test("free relinks in address order");

    expected = ref_alloc(32'd8);
    run_op(1'b1, 32'd8, 32'd0, expected, 6); // result held off for 6 cycles
    check_list();
    finish_test("result held under back-pressure");

    repeat (2) @(posedge clk);
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, proc_errors + prop_errors);
    if (proc_errors + prop_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/heap_pkg.sv
rtl/request_intake.sv
walker/block_splitter.sv
walker/free_list_walker.sv
rtl/header_writer.sv
rtl/heap_alloc_top.sv
tests/heap_mem_model.sv
tests/heap_alloc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= heap_alloc_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
